// ==== Bender.yml ====
package:
  name: convPoolLayer

sources:
  - src/cnnPkg.sv
  - src/kernelRegs.sv
  - src/windowBuffer.sv
  - src/convMac.sv
  - src/maxPool.sv
  - src/convPoolLayer.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/convPoolLayerTb.sv

// ==== sim/tbUtils.svh ====
`ifndef TB_UTILS_SVH
`define TB_UTILS_SVH

logic [31:0] lcgState = 32'h8b07_f58f;

// 32-bit LCG, upper bits returned since the low ones cycle fast
function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {8'h00, lcgState[31:8]};
endfunction

// expected pooled sample from the current frame and coefficients
function automatic cnnPkg::poolSampleT refPool(input int pr, input int pc);
    cnnPkg::poolSampleT res;
    int best;
    int sum;
    int pixIdx;
    best = 0;
    for (int dr = 0; dr < 2; dr++) begin
        for (int dc = 0; dc < 2; dc++) begin
            sum = int'(biasVal);
            for (int kr = 0; kr < cnnPkg::kerSize; kr++) begin
                for (int kc = 0; kc < cnnPkg::kerSize; kc++) begin
                    pixIdx = (2 * pr + dr + kr) * cnnPkg::imgSize + 2 * pc + dc + kc;
                    sum += int'(tapVal[kr * cnnPkg::kerSize + kc]) * int'(framePix[pixIdx]);
                end
            end
            if ((dr == 0 && dc == 0) || sum > best) begin
                best = sum;
            end
        end
    end
    res.value = cnnPkg::accT'(best);
    res.row   = cnnPkg::poolCoordW'(pr);
    res.col   = cnnPkg::poolCoordW'(pc);
    return res;
endfunction

task automatic checkPool(input string name, input cnnPkg::poolSampleT expected,
                         input cnnPkg::poolSampleT actual);
    if (actual !== expected) begin
        valueErrors++;
        $display("[FAIL] %0t %s expected value %0d at (%0d,%0d) got value %0d at (%0d,%0d)",
                 $time, name, expected.value, expected.row, expected.col,
                 actual.value, actual.row, actual.col);
    end
endtask

task automatic checkCount(input string name, input int expected, input int actual);
    if (actual != expected) begin
        countErrors++;
        $display("[FAIL] %0t %s expected %0d samples got %0d", $time, name, expected, actual);
    end
endtask

task automatic checkLatency(input string name, input int expected, input int actual);
    if (actual != expected) begin
        latencyErrors++;
        $display("[FAIL] %0t %s expected %0d cycles got %0d", $time, name, expected, actual);
    end
endtask

`endif

// ==== sim/convPoolLayerTb.sv ====
`timescale 1ns/1ps

module convPoolLayerTb;

    localparam int framePixels = cnnPkg::imgSize * cnnPkg::imgSize;
    localparam int poolCount   = cnnPkg::poolSize * cnnPkg::poolSize;
    localparam int maxGap      = 3;
    // identity, random, gaps, two reload frames, latency
    localparam int totalPixels = 6 * framePixels;
    localparam real watchdogNs = totalPixels * (maxGap + 1) * 40.0 + 2000.0;

    logic               clock;
    logic               rstN;
    logic               pixValid;
    cnnPkg::pixelT      pixData;
    logic               coefValid;
    cnnPkg::coefWriteT  coefWr;
    logic               poolValid;
    cnnPkg::poolSampleT poolOut;

    int cycle;
    int valueErrors;
    int countErrors;
    int latencyErrors;

    // current frame and coefficients, shared with the model
    cnnPkg::pixelT  framePix [framePixels];
    cnnPkg::weightT tapVal [cnnPkg::numTaps];
    cnnPkg::weightT biasVal;
    int             pixCycle [framePixels];

    cnnPkg::poolSampleT gotQ [$];
    int                 gotCycle [$];

    `include "tbUtils.svh"

    convPoolLayer uut (
        .clock     (clock),
        .rstN      (rstN),
        .pixValid  (pixValid),
        .pixData   (pixData),
        .coefValid (coefValid),
        .coefWr    (coefWr),
        .poolValid (poolValid),
        .poolOut   (poolOut)
    );

    initial begin
        clock = 1'b0;
    end

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // outputs sampled mid-cycle, away from the rising edge
    always @(negedge clock) begin
        if (rstN && poolValid) begin
            gotQ.push_back(poolOut);
            gotCycle.push_back(cycle);
        end
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic loadCoefs();
        for (int i = 0; i <= cnnPkg::numTaps; i++) begin
            @(negedge clock);
            coefValid   = 1'b1;
            coefWr.addr = cnnPkg::tapIdxT'(i);
            if (i < cnnPkg::numTaps) begin
                coefWr.data = tapVal[i];
            end else begin
                coefWr.data = biasVal;
            end
        end
        // out of range address, must not disturb anything
        @(negedge clock);
        coefWr.addr = 4'hf;
        coefWr.data = cnnPkg::weightT'(nextRand());
        @(negedge clock);
        coefValid = 1'b0;
    endtask

    task automatic randomizeSetup();
        for (int i = 0; i < cnnPkg::numTaps; i++) begin
            tapVal[i] = cnnPkg::weightT'(nextRand());
        end
        biasVal = cnnPkg::weightT'(nextRand());
        for (int p = 0; p < framePixels; p++) begin
            framePix[p] = cnnPkg::pixelT'(nextRand());
        end
    endtask

    task automatic sendFrame(input int gapMax);
        int gap;
        gotQ.delete();
        gotCycle.delete();
        for (int p = 0; p < framePixels; p++) begin
            @(negedge clock);
            pixValid    = 1'b1;
            pixData     = framePix[p];
            pixCycle[p] = cycle;
            if (gapMax > 0) begin
                gap = int'(nextRand() % (gapMax + 1));
                repeat (gap) begin
                    @(negedge clock);
                    pixValid = 1'b0;
                end
            end
        end
        @(negedge clock);
        pixValid = 1'b0;
    endtask

    // nine samples or give up, then let stray extras show up
    task automatic waitFrame(input string name);
        int waited;
        waited = 0;
        while (gotQ.size() < poolCount && waited < 32) begin
            @(negedge clock);
            waited++;
        end
        repeat (6) @(negedge clock);
        checkCount({name, " poolValid"}, poolCount, gotQ.size());
    endtask

    task automatic compareModel(input string name);
        int n;
        n = (gotQ.size() < poolCount) ? gotQ.size() : poolCount;
        for (int i = 0; i < n; i++) begin
            checkPool({name, " poolOut"}, refPool(i / cnnPkg::poolSize, i % cnnPkg::poolSize),
                      gotQ[i]);
        end
    endtask

    task automatic testReset();
        gotQ.delete();
        repeat (20) @(negedge clock);
        checkCount("reset poolValid", 0, gotQ.size());
    endtask

    task automatic testIdentity();
        cnnPkg::poolSampleT expected;
        int n;
        for (int i = 0; i < cnnPkg::numTaps; i++) begin
            tapVal[i] = (i == 4) ? 8'sd1 : 8'sd0;
        end
        biasVal = 8'sd0;
        for (int p = 0; p < framePixels; p++) begin
            framePix[p] = cnnPkg::pixelT'(p);
        end
        loadCoefs();
        sendFrame(0);
        waitFrame("identity");
        n = (gotQ.size() < poolCount) ? gotQ.size() : poolCount;
        for (int i = 0; i < n; i++) begin
            // ascending image, so the max is the bottom-right centre pixel
            expected.row   = cnnPkg::poolCoordW'(i / cnnPkg::poolSize);
            expected.col   = cnnPkg::poolCoordW'(i % cnnPkg::poolSize);
            expected.value = cnnPkg::accT'((2 * expected.row + 2) * cnnPkg::imgSize
                                           + 2 * expected.col + 2);
            checkPool("identity poolOut", expected, gotQ[i]);
        end
    endtask

    task automatic testRandomFrame();
        randomizeSetup();
        loadCoefs();
        sendFrame(0);
        waitFrame("random");
        compareModel("random");
    endtask

    task automatic testGaps();
        randomizeSetup();
        loadCoefs();
        sendFrame(maxGap);
        waitFrame("gaps");
        compareModel("gaps");
    endtask

    task automatic testReload();
        for (int f = 0; f < 2; f++) begin
            randomizeSetup();
            loadCoefs();
            sendFrame(0);
            waitFrame("reload");
            compareModel("reload");
        end
    endtask

    task automatic testLatency();
        int src;
        int n;
        randomizeSetup();
        loadCoefs();
        sendFrame(0);
        waitFrame("latency");
        compareModel("latency");
        n = (gotCycle.size() < poolCount) ? gotCycle.size() : poolCount;
        for (int i = 0; i < n; i++) begin
            src = (2 * (i / cnnPkg::poolSize) + 3) * cnnPkg::imgSize
                  + 2 * (i % cnnPkg::poolSize) + 3;
            checkLatency("poolValid latency", 4, gotCycle[i] - pixCycle[src]);
        end
    endtask

    initial begin
        cycle         = 0;
        valueErrors   = 0;
        countErrors   = 0;
        latencyErrors = 0;
        rstN          = 1'b0;
        pixValid      = 1'b0;
        pixData       = '0;
        coefValid     = 1'b0;
        coefWr        = '0;
        repeat (3) @(negedge clock);
        rstN = 1'b1;

        testReset();
        testIdentity();
        testRandomFrame();
        testGaps();
        testReload();
        testLatency();

        $display("errors: value %0d, count %0d, latency %0d",
                 valueErrors, countErrors, latencyErrors);
        if (valueErrors + countErrors + latencyErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+sim
src/cnnPkg.sv
src/kernelRegs.sv
src/windowBuffer.sv
src/convMac.sv
src/maxPool.sv
src/convPoolLayer.sv
sim/convPoolLayerTb.sv

// ==== src/cnnPkg.sv ====
package cnnPkg;

    // image and kernel geometry
    localparam int imgSize  = 8;
    localparam int kerSize  = 3;
    localparam int convSize = imgSize - kerSize + 1;
    localparam int poolSize = convSize / 2;
    localparam int numTaps  = kerSize * kerSize;

    // datapath widths
    localparam int pixW  = 8;
    localparam int wgtW  = 8;
    localparam int prodW = pixW + wgtW;
    localparam int accW  = 20;

    // coordinate and address widths
    localparam int imgCoordW  = $clog2(imgSize);
    localparam int convCoordW = $clog2(convSize);
    localparam int poolCoordW = $clog2(poolSize);
    localparam int tapIdxW    = 4;

    typedef logic signed [pixW-1:0]  pixelT;
    typedef logic signed [wgtW-1:0]  weightT;
    typedef logic signed [prodW-1:0] prodT;
    typedef logic signed [accW-1:0]  accT;
    typedef logic [tapIdxW-1:0]      tapIdxT;

    // addresses 0..8 are taps in row-major kernel order, 9 is the bias
    localparam tapIdxT biasIdx = tapIdxT'(numTaps);

    typedef struct packed {
        tapIdxT addr;
        weightT data;
    } coefWriteT;

    typedef struct packed {
        weightT [numTaps-1:0] taps;
        weightT               bias;
    } coefSetT;

    // pixels in tap order, coordinates of the matching conv output
    typedef struct packed {
        pixelT [numTaps-1:0]   pix;
        logic [convCoordW-1:0] row;
        logic [convCoordW-1:0] col;
    } windowT;

    typedef struct packed {
        accT                   value;
        logic [convCoordW-1:0] row;
        logic [convCoordW-1:0] col;
    } convSampleT;

    typedef struct packed {
        accT                   value;
        logic [poolCoordW-1:0] row;
        logic [poolCoordW-1:0] col;
    } poolSampleT;

endpackage

// ==== src/convMac.sv ====
`timescale 1ns/1ps

module convMac (
    input  logic               clock,
    input  logic               rstN,
    input  logic               winValid,
    input  cnnPkg::windowT     win,
    input  cnnPkg::coefSetT    coefs,
    output logic               convValid,
    output cnnPkg::convSampleT conv
);

    // stage one holds the products and the coordinates
    cnnPkg::prodT                  prodReg [cnnPkg::numTaps];
    logic                          stageValid;
    logic [cnnPkg::convCoordW-1:0] stageRow;
    logic [cnnPkg::convCoordW-1:0] stageCol;
    cnnPkg::accT                   sumComb;

    // adder tree input, bias sign-extended into the sum
    always_comb begin
        sumComb = cnnPkg::accT'(coefs.bias);
        for (int i = 0; i < cnnPkg::numTaps; i++) begin
            sumComb = sumComb + cnnPkg::accT'(prodReg[i]);
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            stageValid <= 1'b0;
            convValid  <= 1'b0;
        end else begin
            stageValid <= winValid;
            convValid  <= stageValid;
        end
    end

    always_ff @(posedge clock) begin
        if (winValid) begin
            for (int i = 0; i < cnnPkg::numTaps; i++) begin
                prodReg[i] <= cnnPkg::prodT'(win.pix[i]) * cnnPkg::prodT'(coefs.taps[i]);
            end
            stageRow <= win.row;
            stageCol <= win.col;
        end
        if (stageValid) begin
            conv.value <= sumComb;
            conv.row   <= stageRow;
            conv.col   <= stageCol;
        end
    end

endmodule

// ==== src/convPoolLayer.sv ====
`timescale 1ns/1ps

module convPoolLayer (
    input  logic               clock,
    input  logic               rstN,
    input  logic               pixValid,
    input  cnnPkg::pixelT      pixData,
    input  logic               coefValid,
    input  cnnPkg::coefWriteT  coefWr,
    output logic               poolValid,
    output cnnPkg::poolSampleT poolOut
);

    cnnPkg::coefSetT    coefs;
    logic               winValid;
    cnnPkg::windowT     win;
    logic               convValid;
    cnnPkg::convSampleT conv;

    kernelRegs uKernelRegs (
        .clock     (clock),
        .rstN      (rstN),
        .coefValid (coefValid),
        .coefWr    (coefWr),
        .coefs     (coefs)
    );

    // window out one cycle after the completing pixel
    windowBuffer uWindowBuffer (
        .clock    (clock),
        .rstN     (rstN),
        .pixValid (pixValid),
        .pixData  (pixData),
        .winValid (winValid),
        .win      (win)
    );

    // two register stages, products then sum
    convMac uConvMac (
        .clock     (clock),
        .rstN      (rstN),
        .winValid  (winValid),
        .win       (win),
        .coefs     (coefs),
        .convValid (convValid),
        .conv      (conv)
    );

    maxPool uMaxPool (
        .clock     (clock),
        .rstN      (rstN),
        .convValid (convValid),
        .conv      (conv),
        .poolValid (poolValid),
        .poolOut   (poolOut)
    );

endmodule

// ==== src/kernelRegs.sv ====
`timescale 1ns/1ps

module kernelRegs (
    input  logic              clock,
    input  logic              rstN,
    input  logic              coefValid,
    input  cnnPkg::coefWriteT coefWr,
    output cnnPkg::coefSetT   coefs
);

    // one entry per strobe, addresses above the bias fall through
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            coefs <= '0;
        end else if (coefValid) begin
            for (int i = 0; i < cnnPkg::numTaps; i++) begin
                if (coefWr.addr == cnnPkg::tapIdxT'(i)) begin
                    coefs.taps[i] <= coefWr.data;
                end
            end
            if (coefWr.addr == cnnPkg::biasIdx) begin
                coefs.bias <= coefWr.data;
            end
        end
    end

endmodule

// ==== src/maxPool.sv ====
`timescale 1ns/1ps

module maxPool (
    input  logic               clock,
    input  logic               rstN,
    input  logic               convValid,
    input  cnnPkg::convSampleT conv,
    output logic               poolValid,
    output cnnPkg::poolSampleT poolOut
);

    // max of the even column, waiting for its odd neighbour
    cnnPkg::accT hMax;

    // pair maxima of the even conv row, one per pooled column
    cnnPkg::accT partial [cnnPkg::poolSize];

    cnnPkg::accT                   pairMax;
    cnnPkg::accT                   quadMax;
    logic [cnnPkg::poolCoordW-1:0] poolCol;
    logic [cnnPkg::poolCoordW-1:0] poolRow;
    logic                          colOdd;
    logic                          rowOdd;

    assign colOdd  = conv.col[0];
    assign rowOdd  = conv.row[0];
    assign poolCol = conv.col[cnnPkg::convCoordW-1:1];
    assign poolRow = conv.row[cnnPkg::convCoordW-1:1];

    always_comb begin
        pairMax = (conv.value > hMax) ? conv.value : hMax;
        quadMax = (partial[poolCol] > pairMax) ? partial[poolCol] : pairMax;
    end

    // emit on the bottom-right sample of each 2x2 block
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            poolValid <= 1'b0;
        end else begin
            poolValid <= convValid && rowOdd && colOdd;
        end
    end

    always_ff @(posedge clock) begin
        if (convValid) begin
            if (!colOdd) begin
                // start a new horizontal pair
                hMax <= conv.value;
            end else if (!rowOdd) begin
                partial[poolCol] <= pairMax;
            end else begin
                poolOut.value <= quadMax;
                poolOut.row   <= poolRow;
                poolOut.col   <= poolCol;
            end
        end
    end

endmodule

// ==== src/windowBuffer.sv ====
`timescale 1ns/1ps

module windowBuffer (
    input  logic           clock,
    input  logic           rstN,
    input  logic           pixValid,
    input  cnnPkg::pixelT  pixData,
    output logic           winValid,
    output cnnPkg::windowT win
);

    logic [cnnPkg::imgCoordW-1:0] rowCnt;
    logic [cnnPkg::imgCoordW-1:0] colCnt;
    logic                         fullWindow;

    // two previous image rows, indexed by column
    cnnPkg::pixelT lineTop [cnnPkg::imgSize];
    cnnPkg::pixelT lineMid [cnnPkg::imgSize];

    // column entering the window, top to bottom
    cnnPkg::pixelT newCol [cnnPkg::kerSize];

    assign fullWindow = (rowCnt >= cnnPkg::kerSize - 1) && (colCnt >= cnnPkg::kerSize - 1);

    always_comb begin
        newCol[0] = lineTop[colCnt];
        newCol[1] = lineMid[colCnt];
        newCol[2] = pixData;
    end

    // raster position, wraps after a full frame
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            rowCnt   <= '0;
            colCnt   <= '0;
            winValid <= 1'b0;
        end else begin
            winValid <= pixValid && fullWindow;
            if (pixValid) begin
                if (colCnt == cnnPkg::imgCoordW'(cnnPkg::imgSize - 1)) begin
                    colCnt <= '0;
                    if (rowCnt == cnnPkg::imgCoordW'(cnnPkg::imgSize - 1)) begin
                        rowCnt <= '0;
                    end else begin
                        rowCnt <= rowCnt + 1'b1;
                    end
                end else begin
                    colCnt <= colCnt + 1'b1;
                end
            end
        end
    end

    // line buffers and the shifting 3x3 window
    always_ff @(posedge clock) begin
        if (pixValid) begin
            lineTop[colCnt] <= lineMid[colCnt];
            lineMid[colCnt] <= pixData;
            for (int kr = 0; kr < cnnPkg::kerSize; kr++) begin
                for (int kc = 0; kc < cnnPkg::kerSize - 1; kc++) begin
                    win.pix[kr*cnnPkg::kerSize+kc] <= win.pix[kr*cnnPkg::kerSize+kc+1];
                end
                win.pix[kr*cnnPkg::kerSize+cnnPkg::kerSize-1] <= newCol[kr];
            end
            // window anchored at its top-left pixel
            win.row <= cnnPkg::convCoordW'(rowCnt - cnnPkg::imgCoordW'(cnnPkg::kerSize - 1));
            win.col <= cnnPkg::convCoordW'(colCnt - cnnPkg::imgCoordW'(cnnPkg::kerSize - 1));
        end
    end

endmodule
